//--- source/armPkg.sv
package armPkg;

    // Widths that carry a meaning
    typedef logic [63:0] dataWordT;
    typedef logic [31:0] instrWordT;
    typedef logic [31:0] instrAddrT;
    typedef logic [4:0]  regIndexT;

    // ALU operations
    typedef enum logic [2:0]
    {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluShl,
        aluShr
    } aluOpT;

    // X31 reads as zero and ignores writes
    localparam regIndexT zeroReg = 5'd31;

    // Opcode group codes in the top six bits of the instruction
    localparam logic [5:0] opR = 6'b001010;
    localparam logic [5:0] opI = 6'b100010;
    localparam logic [5:0] opD = 6'b110100;

    // R-format function codes
    localparam logic [4:0] funcAdd = 5'd0;
    localparam logic [4:0] funcAnd = 5'd2;
    localparam logic [4:0] funcEor = 5'd4;
    localparam logic [4:0] funcLsl = 5'd6;
    localparam logic [4:0] funcLsr = 5'd7;
    localparam logic [4:0] funcOrr = 5'd8;
    localparam logic [4:0] funcSub = 5'd9;

    // I-format function codes
    localparam logic [3:0] funcAddi = 4'd0;
    localparam logic [3:0] funcAndi = 4'd2;
    localparam logic [3:0] funcOrri = 4'd6;
    localparam logic [3:0] funcSubi = 4'd7;

    // D-format function codes
    localparam logic [4:0] funcLdur = 5'd0;
    localparam logic [4:0] funcStur = 5'd1;

    // PC increment
    localparam instrAddrT instrStep = 32'd4;

    // ADD X31,X31,X31
    localparam instrWordT nopInstr = 32'h281F_03FF;

endpackage

//--- source/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
(
    input  logic              clk,
    input  logic              reset,
    input  armPkg::instrWordT ibus,
    output armPkg::instrAddrT iaddrbus,
    output armPkg::instrWordT instr
);
    import armPkg::*;

    // Program counter only steps since there are no branches
    always_ff @(posedge clk)
    begin
        if (reset)
            iaddrbus <= '0;
        else
            iaddrbus <= iaddrbus + instrStep;
    end

    // IF/ID register holds a NOP until the first fetch lands
    always_ff @(posedge clk)
    begin
        if (reset)
            instr <= nopInstr;
        else
            instr <= ibus;
    end

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
(
    input  armPkg::instrWordT instr,
    output armPkg::regIndexT  readIndexA,
    output armPkg::regIndexT  readIndexB,
    output armPkg::regIndexT  destIndex,
    output armPkg::aluOpT     aluOp,
    output logic              useImm,
    output logic              regWrite,
    output logic              isLoad,
    output logic              isStore,
    output armPkg::dataWordT  immValue
);
    import armPkg::*;

    logic [5:0] opGroup;
    logic [4:0] funcR;
    logic [3:0] funcI;
    dataWordT   aluImm;
    dataWordT   shamtImm;
    dataWordT   dtImm;

    // Opcode [31:21] split into group and function
    assign opGroup = instr[31:26];
    assign funcR   = instr[25:21];
    assign funcI   = instr[25:22];

    // Rd/Rt [4:0], Rn [9:5], Rm [20:16]
    assign destIndex  = instr[4:0];
    assign readIndexA = instr[9:5];
    // Stores read Rt as the data operand
    assign readIndexB = isStore ? instr[4:0] : instr[20:16];

    // ALU immediate [21:10], shamt [15:10], DT offset [20:12]
    assign aluImm   = {{52{instr[21]}}, instr[21:10]};
    assign shamtImm = {58'd0, instr[15:10]};
    assign dtImm    = {{55{instr[20]}}, instr[20:12]};

    always_comb
    begin
        aluOp    = aluAdd;
        useImm   = 1'b0;
        regWrite = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        immValue = aluImm;
        case (opGroup)
            opR:
            begin
                regWrite = 1'b1;
                immValue = shamtImm;
                case (funcR)
                    funcAdd: aluOp = aluAdd;
                    funcSub: aluOp = aluSub;
                    funcAnd: aluOp = aluAnd;
                    funcOrr: aluOp = aluOr;
                    funcEor: aluOp = aluXor;
                    funcLsl:
                    begin
                        aluOp  = aluShl;
                        useImm = 1'b1;
                    end
                    funcLsr:
                    begin
                        aluOp  = aluShr;
                        useImm = 1'b1;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            opI:
            begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                case (funcI)
                    funcAddi: aluOp = aluAdd;
                    funcSubi: aluOp = aluSub;
                    funcAndi: aluOp = aluAnd;
                    funcOrri: aluOp = aluOr;
                    default:  regWrite = 1'b0;
                endcase
            end
            opD:
            begin
                // Address is always base plus offset
                useImm   = 1'b1;
                immValue = dtImm;
                case (funcR)
                    funcLdur:
                    begin
                        isLoad   = 1'b1;
                        regWrite = 1'b1;
                    end
                    funcStur: isStore = 1'b1;
                    default:  ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile
(
    input  logic             clk,
    input  armPkg::regIndexT readIndexA,
    input  armPkg::regIndexT readIndexB,
    input  armPkg::regIndexT writeIndex,
    input  logic             writeEnable,
    input  armPkg::dataWordT writeData,
    output armPkg::dataWordT readDataA,
    output armPkg::dataWordT readDataB
);
    import armPkg::*;

    dataWordT regs [32];

    always_ff @(posedge clk)
    begin
        if (writeEnable && writeIndex != zeroReg)
            regs[writeIndex] <= writeData;
    end

    // Zero register first, then same-cycle write bypass
    always_comb
    begin
        if (readIndexA == zeroReg)
            readDataA = '0;
        else if (writeEnable && readIndexA == writeIndex)
            readDataA = writeData;
        else
            readDataA = regs[readIndexA];

        if (readIndexB == zeroReg)
            readDataB = '0;
        else if (writeEnable && readIndexB == writeIndex)
            readDataB = writeData;
        else
            readDataB = regs[readIndexB];
    end

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
    input  logic             clk,
    input  logic             reset,
    input  armPkg::dataWordT operandA,
    input  armPkg::dataWordT operandB,
    input  armPkg::dataWordT immValue,
    input  armPkg::aluOpT    aluOp,
    input  logic             useImm,
    input  logic             regWrite,
    input  logic             isLoad,
    input  logic             isStore,
    input  armPkg::regIndexT destIndex,
    output armPkg::dataWordT aluResult,
    output armPkg::dataWordT storeValue,
    output logic             exRegWrite,
    output logic             exLoad,
    output logic             exStore,
    output armPkg::regIndexT exDest
);
    import armPkg::*;

    dataWordT    exA;
    dataWordT    exImm;
    aluOpT       exOp;
    logic        exUseImm;
    dataWordT    opB;
    dataWordT    addB;
    dataWordT    sum;
    logic        carryIn;
    // Heap-ordered tree with node 1 as the root and 64..127 as bit leaves
    logic [127:2] gNode;
    logic [127:2] pNode;
    logic [127:1] cNode;

    // ID/EX controls
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exRegWrite <= 1'b0;
            exLoad     <= 1'b0;
            exStore    <= 1'b0;
        end
        else
        begin
            exRegWrite <= regWrite;
            exLoad     <= isLoad;
            exStore    <= isStore;
        end
    end

    // ID/EX operands
    always_ff @(posedge clk)
    begin
        exA        <= operandA;
        storeValue <= operandB;
        exImm      <= immValue;
        exOp       <= aluOp;
        exUseImm   <= useImm;
        exDest     <= destIndex;
    end

    assign opB = exUseImm ? exImm : storeValue;

    // Subtract as A + ~B + 1
    assign carryIn = (exOp == aluSub);
    assign addB    = carryIn ? ~opB : opB;

    assign cNode[1] = carryIn;

    for (genvar i = 0; i < 64; i++)
    begin : g_leaf
        assign gNode[64 + i] = exA[i] & addB[i];
        assign pNode[64 + i] = exA[i] ^ addB[i];
        assign sum[i]        = pNode[64 + i] ^ cNode[64 + i];
    end

    // Generate/propagate up to the children of the root
    for (genvar j = 2; j < 64; j++)
    begin : g_node
        assign gNode[j] = gNode[2*j + 1] | (pNode[2*j + 1] & gNode[2*j]);
        assign pNode[j] = pNode[2*j + 1] & pNode[2*j];
    end

    // Carries back down from the root
    for (genvar j = 1; j < 64; j++)
    begin : g_carry
        assign cNode[2*j]     = cNode[j];
        assign cNode[2*j + 1] = gNode[2*j] | (pNode[2*j] & cNode[j]);
    end

    always_comb
    begin
        case (exOp)
            aluAnd:  aluResult = exA & opB;
            aluOr:   aluResult = exA | opB;
            aluXor:  aluResult = exA ^ opB;
            aluShl:  aluResult = exA << opB[5:0];
            aluShr:  aluResult = exA >> opB[5:0];
            default: aluResult = sum;
        endcase
    end

endmodule

//--- source/memoryStage.sv
`timescale 1ns/1ps

module memoryStage
(
    input  logic             clk,
    input  logic             reset,
    input  armPkg::dataWordT aluResult,
    input  armPkg::dataWordT storeValue,
    input  logic             exRegWrite,
    input  logic             exLoad,
    input  logic             exStore,
    input  armPkg::regIndexT exDest,
    input  armPkg::dataWordT loadData,
    output armPkg::dataWordT daddrbus,
    output armPkg::dataWordT storeData,
    output logic             storeEnable,
    output logic             loadEnable,
    output armPkg::regIndexT writeIndex,
    output logic             writeEnable,
    output armPkg::dataWordT writeData
);
    import armPkg::*;

    logic     memRegWrite;
    regIndexT memDest;

    // EX/MEM strobes live for one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            storeEnable <= 1'b0;
            loadEnable  <= 1'b0;
            memRegWrite <= 1'b0;
        end
        else
        begin
            storeEnable <= exStore;
            loadEnable  <= exLoad;
            memRegWrite <= exRegWrite;
        end
    end

    always_ff @(posedge clk)
    begin
        daddrbus  <= aluResult;
        storeData <= storeValue;
        memDest   <= exDest;
    end

    // MEM/WB
    always_ff @(posedge clk)
    begin
        if (reset)
            writeEnable <= 1'b0;
        else
            writeEnable <= memRegWrite;
    end

    always_ff @(posedge clk)
    begin
        writeIndex <= memDest;
        writeData  <= loadEnable ? loadData : daddrbus;
    end

endmodule

//--- source/armPipeline.sv
`timescale 1ns/1ps

module armPipeline
(
    input  logic              clk,
    input  logic              reset,
    input  armPkg::instrWordT ibus,
    output armPkg::instrAddrT iaddrbus,
    output armPkg::dataWordT  daddrbus,
    output armPkg::dataWordT  storeData,
    input  armPkg::dataWordT  loadData,
    output logic              storeEnable,
    output logic              loadEnable
);
    import armPkg::*;

    // Decode stage
    instrWordT instr;
    regIndexT  readIndexA;
    regIndexT  readIndexB;
    regIndexT  destIndex;
    aluOpT     aluOp;
    logic      useImm;
    logic      regWrite;
    logic      isLoad;
    logic      isStore;
    dataWordT  immValue;
    dataWordT  readDataA;
    dataWordT  readDataB;

    // Execute stage
    dataWordT  aluResult;
    dataWordT  storeValue;
    logic      exRegWrite;
    logic      exLoad;
    logic      exStore;
    regIndexT  exDest;

    // Writeback
    regIndexT  writeIndex;
    logic      writeEnable;
    dataWordT  writeData;

    fetchUnit i_fetchUnit
    (
        .clk(clk),
        .reset(reset),
        .ibus(ibus),
        .iaddrbus(iaddrbus),
        .instr(instr)
    );

    instrDecoder i_instrDecoder
    (
        .instr(instr),
        .readIndexA(readIndexA),
        .readIndexB(readIndexB),
        .destIndex(destIndex),
        .aluOp(aluOp),
        .useImm(useImm),
        .regWrite(regWrite),
        .isLoad(isLoad),
        .isStore(isStore),
        .immValue(immValue)
    );

    registerFile i_registerFile
    (
        .clk(clk),
        .readIndexA(readIndexA),
        .readIndexB(readIndexB),
        .writeIndex(writeIndex),
        .writeEnable(writeEnable),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    executeStage i_executeStage
    (
        .clk(clk),
        .reset(reset),
        .operandA(readDataA),
        .operandB(readDataB),
        .immValue(immValue),
        .aluOp(aluOp),
        .useImm(useImm),
        .regWrite(regWrite),
        .isLoad(isLoad),
        .isStore(isStore),
        .destIndex(destIndex),
        .aluResult(aluResult),
        .storeValue(storeValue),
        .exRegWrite(exRegWrite),
        .exLoad(exLoad),
        .exStore(exStore),
        .exDest(exDest)
    );

    memoryStage i_memoryStage
    (
        .clk(clk),
        .reset(reset),
        .aluResult(aluResult),
        .storeValue(storeValue),
        .exRegWrite(exRegWrite),
        .exLoad(exLoad),
        .exStore(exStore),
        .exDest(exDest),
        .loadData(loadData),
        .daddrbus(daddrbus),
        .storeData(storeData),
        .storeEnable(storeEnable),
        .loadEnable(loadEnable),
        .writeIndex(writeIndex),
        .writeEnable(writeEnable),
        .writeData(writeData)
    );

endmodule

//--- verif/armPipeline_properties.sv
`timescale 1ns/1ps

module armPipeline_properties
(
    input logic              clk,
    input logic              reset,
    input armPkg::instrAddrT iaddrbus,
    input logic              storeEnable,
    input logic              loadEnable
);

    // PC only ever steps forward by one word
    pcStep: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> iaddrbus == $past(iaddrbus) + 32'd4)
        else $error("iaddrbus did not step by 4");

    strobeExclusive: assert property (@(posedge clk) disable iff (reset)
        !(storeEnable && loadEnable))
        else $error("storeEnable and loadEnable high together");

    // Nothing has reached the memory stage yet
    strobesQuietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> !storeEnable && !loadEnable)
        else $error("memory strobe high right after reset");

endmodule

bind armPipeline armPipeline_properties i_properties
(
    .clk(clk),
    .reset(reset),
    .iaddrbus(iaddrbus),
    .storeEnable(storeEnable),
    .loadEnable(loadEnable)
);

//--- verif/armPipelineTb.sv
`timescale 1ns/1ps

module armPipelineTb;
    import armPkg::*;

    localparam int clockPeriod = 20;
    localparam int resetCycles = 5;
    localparam int drainCycles = 8;
    localparam int numTests = 6;
    localparam int unsigned randomSeed = 32'he64a894d;
    // Idle, immediate, ALU, shift, offset and zero-register programs
    localparam int programCycles = 16 + 24 + 36 + 39 + 9 + 12;
    localparam int watchdogCycles =
        programCycles + numTests * (resetCycles + 1 + drainCycles) + 50;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      resetRequest = 1'b1;
    instrWordT ibus = nopInstr;
    instrAddrT iaddrbus;
    dataWordT  daddrbus;
    dataWordT  storeData;
    dataWordT  loadData = '0;
    logic      storeEnable;
    logic      loadEnable;

    // Program, data memory and what the memory side saw
    instrWordT instrMem [$];
    dataWordT  dataMem [dataWordT];
    dataWordT  storeAddrQ [$];
    dataWordT  storeDataQ [$];
    dataWordT  loadAddrQ [$];
    dataWordT  expStoreAddr [$];
    dataWordT  expStoreData [$];
    dataWordT  expLoadAddr [$];
    int        fetchCount = 0;
    int        storeStart = 0;
    int        loadStart = 0;
    int        errorCount = 0;
    int        errorStart = 0;
    int        checkCount = 0;
    int        testCount = 0;

    armPipeline i_dut
    (
        .clk(clk),
        .reset(reset),
        .ibus(ibus),
        .iaddrbus(iaddrbus),
        .daddrbus(daddrbus),
        .storeData(storeData),
        .loadData(loadData),
        .storeEnable(storeEnable),
        .loadEnable(loadEnable)
    );

    always #(clockPeriod / 2) clk = ~clk;

    always @(posedge clk)
    begin
        reset <= resetRequest;
    end

    function automatic instrWordT fetchWord(int index);
        if (index < instrMem.size())
            return instrMem[index];
        return nopInstr;
    endfunction

    function automatic dataWordT readWord(dataWordT addr);
        return dataMem.exists(addr) ? dataMem[addr] : '0;
    endfunction

    // Fetch counter mirrors the PC with zero in reset and one word per edge after
    always @(posedge clk)
    begin
        fetchCount <= reset ? 0 : fetchCount + 1;
        ibus <= fetchWord(reset ? 0 : fetchCount + 1);
    end

    // Word goes out one edge early so it is on loadData while loadEnable is high
    always @(posedge clk)
    begin
        if (i_dut.exLoad)
            loadData <= readWord(i_dut.aluResult);
        if (storeEnable)
        begin
            storeAddrQ.push_back(daddrbus);
            storeDataQ.push_back(storeData);
        end
        if (loadEnable)
            loadAddrQ.push_back(daddrbus);
    end

    function automatic instrWordT encodeR(logic [4:0] func, regIndexT rd, regIndexT rn,
                                          regIndexT rm, logic [5:0] shamt);
        return {opR, func, rm, shamt, rn, rd};
    endfunction

    function automatic instrWordT encodeI(logic [3:0] func, regIndexT rd, regIndexT rn,
                                          logic [11:0] imm);
        return {opI, func, imm, rn, rd};
    endfunction

    function automatic instrWordT encodeD(logic [4:0] func, regIndexT rt, regIndexT rn,
                                          logic [8:0] offset);
        return {opD, func, offset, 2'b00, rn, rt};
    endfunction

    function automatic dataWordT extend12(logic [11:0] value);
        return {{52{value[11]}}, value};
    endfunction

    function automatic dataWordT extend9(logic [8:0] value);
        return {{55{value[8]}}, value};
    endfunction

    task automatic compareData(string name, dataWordT actual, dataWordT expected);
        checkCount++;
        if (actual !== expected)
        begin
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic compareAddr(string name, instrAddrT actual, instrAddrT expected);
        checkCount++;
        if (actual !== expected)
        begin
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportError(string what);
        $display("ERROR t=%0t %s", $time, what);
        errorCount++;
    endtask

    // Two NOPs after every instruction keep producers and consumers apart
    task automatic addInstr(instrWordT word);
        instrMem.push_back(word);
        instrMem.push_back(nopInstr);
        instrMem.push_back(nopInstr);
    endtask

    task automatic expectStore(dataWordT addr, dataWordT data);
        expStoreAddr.push_back(addr);
        expStoreData.push_back(data);
    endtask

    task automatic expectLoad(dataWordT addr);
        expLoadAddr.push_back(addr);
    endtask

    task automatic beginTest();
        @(negedge clk);
        resetRequest = 1'b1;
        instrMem.delete();
        expStoreAddr.delete();
        expStoreData.delete();
        expLoadAddr.delete();
        dataMem.delete();
        errorStart = errorCount;
    endtask

    // Release reset, wait for the expected stores, then check the memory side
    task automatic runProgram();
        int cycles;
        int seen;
        repeat (resetCycles) @(negedge clk);
        resetRequest = 1'b0;
        @(posedge clk);
        storeStart = storeDataQ.size();
        loadStart = loadAddrQ.size();
        cycles = 0;
        while (storeDataQ.size() - storeStart < expStoreData.size()
               && cycles < instrMem.size() + drainCycles)
        begin
            @(negedge clk);
            cycles++;
        end
        seen = storeDataQ.size() - storeStart;
        if (seen < expStoreData.size())
            reportError($sformatf("only %0d of %0d stores arrived within %0d cycles",
                                  seen, expStoreData.size(), cycles));
        else if (loadAddrQ.size() - loadStart != expLoadAddr.size())
            reportError($sformatf("saw %0d loads, expected %0d",
                                  loadAddrQ.size() - loadStart, expLoadAddr.size()));
        else
        begin
            for (int i = 0; i < expStoreData.size(); i++)
            begin
                compareData($sformatf("daddrbus[store %0d]", i),
                            storeAddrQ[storeStart + i], expStoreAddr[i]);
                compareData($sformatf("storeData[%0d]", i),
                            storeDataQ[storeStart + i], expStoreData[i]);
            end
            for (int i = 0; i < expLoadAddr.size(); i++)
                compareData($sformatf("daddrbus[load %0d]", i),
                            loadAddrQ[loadStart + i], expLoadAddr[i]);
        end
    endtask

    task automatic endTest(string name);
        testCount++;
        $display("test %s finished with %0d errors", name, errorCount - errorStart);
    endtask

    task automatic testIdle();
        beginTest();
        runProgram();
        for (int k = 0; k < 16; k++)
        begin
            @(negedge clk);
            compareAddr("iaddrbus", iaddrbus, instrAddrT'(k * 4));
        end
        if (storeDataQ.size() != storeStart || loadAddrQ.size() != loadStart)
            reportError("a memory strobe fired during the NOP program");
        endTest("idle");
    endtask

    task automatic testImmediate();
        logic [3:0]  funcs [4] = '{funcAddi, funcSubi, funcAndi, funcOrri};
        logic [11:0] imm;
        dataWordT    ext;
        dataWordT    expected;
        beginTest();
        for (int k = 0; k < 4; k++)
        begin
            imm = 12'($urandom);
            ext = extend12(imm);
            // X31 is the first operand, so every result is zero combined with ext
            case (k)
                0: expected = ext;
                1: expected = 64'd0 - ext;
                2: expected = 64'd0;
                default: expected = ext;
            endcase
            addInstr(encodeI(funcs[2'(k)], regIndexT'(k + 1), zeroReg, imm));
            addInstr(encodeD(funcStur, regIndexT'(k + 1), zeroReg, 9'(16 + 8 * k)));
            expectStore(dataWordT'(16 + 8 * k), expected);
        end
        runProgram();
        endTest("immediate");
    endtask

    task automatic testAlu();
        logic [4:0] funcs [5] = '{funcAdd, funcSub, funcAnd, funcOrr, funcEor};
        dataWordT   a;
        dataWordT   b;
        dataWordT   result;
        beginTest();
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        dataMem[64'h40] = a;
        dataMem[64'h48] = b;
        expectLoad(64'h40);
        expectLoad(64'h48);
        addInstr(encodeD(funcLdur, 5'd1, zeroReg, 9'h040));
        addInstr(encodeD(funcLdur, 5'd2, zeroReg, 9'h048));
        for (int k = 0; k < 5; k++)
        begin
            case (k)
                0: result = a + b;
                1: result = a - b;
                2: result = a & b;
                3: result = a | b;
                default: result = a ^ b;
            endcase
            addInstr(encodeR(funcs[3'(k)], regIndexT'(k + 3), 5'd1, 5'd2, 6'd0));
            addInstr(encodeD(funcStur, regIndexT'(k + 3), zeroReg, 9'(128 + 8 * k)));
            expectStore(dataWordT'(128 + 8 * k), result);
        end
        runProgram();
        endTest("alu");
    endtask

    task automatic testShift();
        dataWordT   word;
        logic [5:0] shamt;
        beginTest();
        word = {$urandom, $urandom};
        dataMem[64'h50] = word;
        expectLoad(64'h50);
        addInstr(encodeD(funcLdur, 5'd8, zeroReg, 9'h050));
        for (int k = 0; k < 6; k++)
        begin
            shamt = 6'($urandom);
            if (k % 2 == 0)
            begin
                addInstr(encodeR(funcLsl, 5'd9, 5'd8, zeroReg, shamt));
                expectStore(dataWordT'(96 + 8 * k), word << shamt);
            end
            else
            begin
                addInstr(encodeR(funcLsr, 5'd9, 5'd8, zeroReg, shamt));
                expectStore(dataWordT'(96 + 8 * k), word >> shamt);
            end
            addInstr(encodeD(funcStur, 5'd9, zeroReg, 9'(96 + 8 * k)));
        end
        runProgram();
        endTest("shift");
    endtask

    task automatic testOffset();
        logic [8:0] loadOff;
        logic [8:0] storeOff;
        dataWordT   word;
        beginTest();
        // Offsets from -256 to -1 around a base of 0x200
        loadOff = {1'b1, 8'($urandom)};
        storeOff = {1'b1, 8'($urandom)};
        word = {$urandom, $urandom};
        dataMem[64'h200 + extend9(loadOff)] = word;
        expectLoad(64'h200 + extend9(loadOff));
        expectStore(64'h200 + extend9(storeOff), word);
        addInstr(encodeI(funcAddi, 5'd11, zeroReg, 12'h200));
        addInstr(encodeD(funcLdur, 5'd12, 5'd11, loadOff));
        addInstr(encodeD(funcStur, 5'd12, 5'd11, storeOff));
        runProgram();
        endTest("offset");
    endtask

    task automatic testZeroReg();
        beginTest();
        dataMem[64'h38] = {$urandom, $urandom} | 64'd1;
        expectStore(64'h30, 64'd0);
        expectLoad(64'h38);
        expectStore(64'h40, 64'd0);
        addInstr(encodeI(funcAddi, zeroReg, zeroReg, 12'($urandom) | 12'd1));
        addInstr(encodeD(funcStur, zeroReg, zeroReg, 9'h030));
        addInstr(encodeD(funcLdur, zeroReg, zeroReg, 9'h038));
        addInstr(encodeD(funcStur, zeroReg, zeroReg, 9'h040));
        runProgram();
        endTest("zeroReg");
    endtask

    initial
    begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout, the run went past %0d cycles", watchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        void'($urandom(randomSeed));
        testIdle();
        testImmediate();
        testAlu();
        testShift();
        testOffset();
        testZeroReg();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- vlog.f
source/armPkg.sv
source/fetchUnit.sv
source/instrDecoder.sv
source/registerFile.sv
source/executeStage.sv
source/memoryStage.sv
source/armPipeline.sv
verif/armPipeline_properties.sv
verif/armPipelineTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the armPipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module armPipelineTb -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VarmPipelineTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
